// File: tetrisStim.txt
# commands: reset, press L|R n, hold fall|pause v, waitcell row col timeout,
# waitover timeout, idle n, cell row col expected, over expected, shape hex
reset
cell 0 3 1
cell 0 6 1
cell 0 2 0
cell 0 7 0
cell 1 3 0
shape 4e
over 0
# piece 0 to the right wall
press R 5
waitcell 19 9 600
waitcell 0 4 100
cell 1 3 1
shape cc
cell 19 6 1
cell 19 5 0
# piece 1 to the left wall with fast fall
press L 5
hold fall 1
waitcell 19 0 200
hold fall 0
cell 19 3 0
cell 18 1 1
# piece 2 drops at the spawn column
waitcell 0 3 200
shape 6c
waitcell 19 3 600
# pieces 3 and 4 parked on the left stack
waitcell 0 4 100
shape c6
press L 5
waitcell 16 2 600
waitcell 0 3 100
shape e8
press L 5
waitcell 14 0 600
# piece 5 moved two columns right, right after a gravity step
waitcell 0 5 100
shape 8e
waitcell 1 4 40
press R 2
waitcell 18 7 600
waitcell 0 3 100
shape f0
# row 19 cleared, old row 18 moved down
cell 19 0 0
cell 19 1 1
cell 19 2 0
cell 19 3 1
cell 19 4 1
cell 19 5 1
cell 19 6 1
cell 19 7 1
cell 19 8 0
cell 19 9 0
cell 18 0 1
cell 18 1 1
cell 18 2 0
cell 17 0 0
cell 17 1 1
cell 17 2 1
# pause freezes piece 6 at row 2
waitcell 3 4 40
hold pause 1
press L 2
idle 80
cell 2 3 1
cell 3 5 1
cell 3 2 0
cell 4 4 0
hold pause 0
# stack at the spawn column until game over
hold fall 1
waitover 20000
hold fall 0
over 1
press L 2
press R 2
idle 40
cell 0 2 0
cell 1 2 0
cell 0 7 0
cell 1 7 0
over 1

// File: sim.f
tetrisPkg.sv
gravityTimer.sv
pieceSource.sv
playfield.sv
pieceControl.sv
tetrisTop.sv
tetrisTb.sv

// File: run.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --assert -Wno-fatal -f sim.f --top-module tetrisTb -o tetrisSim

out=$(./obj_dir/tetrisSim || true)
echo "$out"

if grep -q "Simulation passed" <<< "$out"; then
    exit 0
else
    exit 1
fi

// File: tetrisTb.sv
`timescale 1ns/1ps

module tetrisTb;

    logic                 clk;
    logic                 rst_up;
    logic                 left;
    logic                 right;
    logic                 fall;
    logic                 pause;
    tetrisPkg::cellQueryT query;
    logic                 cellFilled;
    logic                 gameOver;
    tetrisPkg::shapeT     nextShape;

    tetrisTop #(
        .tickCycles(16)
    ) i_tetrisTop (
        .clk        (clk),
        .rst_up     (rst_up),
        .left       (left),
        .right      (right),
        .fall       (fall),
        .pause      (pause),
        .query      (query),
        .cellFilled (cellFilled),
        .gameOver   (gameOver),
        .nextShape  (nextShape)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    //////////////////////////////
    // helpers
    //////////////////////////////

    task automatic abortRun();
        $display("Simulation failed");
        $fatal(1, "stopped at first error");
    endtask

    function automatic tetrisPkg::cellQueryT cellAt(input int r, input int c);
        return '{row: tetrisPkg::rowIdxT'(r), col: tetrisPkg::colT'(c)};
    endfunction

    // query on a falling edge, result is registered at the next rising edge
    task automatic checkCell(input tetrisPkg::cellQueryT q, input logic expVal);
        query = q;
        @(posedge clk);
        @(negedge clk);
        if (cellFilled !== expVal) begin
            $display("Error: cellFilled row %0d col %0d got %h expected %h",
                     q.row, q.col, cellFilled, expVal);
            abortRun();
        end
    endtask

    task automatic checkFlag(input string name, input logic got, input logic expVal);
        if (got !== expVal) begin
            $display("Error: %s got %h expected %h", name, got, expVal);
            abortRun();
        end
    endtask

    task automatic checkShape(input tetrisPkg::shapeT got, input tetrisPkg::shapeT expVal);
        if (got !== expVal) begin
            $display("Error: nextShape got %h expected %h", got, expVal);
            abortRun();
        end
    endtask

    task automatic waitCell(input tetrisPkg::cellQueryT q, input int limit);
        int   n;
        logic hit;
        n   = 0;
        hit = 1'b0;
        while (!hit && n < limit) begin
            query = q;
            @(posedge clk);
            @(negedge clk);
            hit = (cellFilled === 1'b1);
            n++;
        end
        if (!hit) begin
            $display("Timeout: cell row %0d col %0d never filled", q.row, q.col);
            abortRun();
        end
    endtask

    task automatic waitGameOver(input int limit);
        int n;
        n = 0;
        while (gameOver !== 1'b1 && n < limit) begin
            @(negedge clk);
            n++;
        end
        if (gameOver !== 1'b1) begin
            $display("Timeout: game over never came");
            abortRun();
        end
    endtask

    // one press every 6 cycles
    task automatic pressButton(input logic isLeft, input int count);
        for (int i = 0; i < count; i++) begin
            if (isLeft) left = 1'b1;
            else right = 1'b1;
            repeat (3) @(negedge clk);
            left  = 1'b0;
            right = 1'b0;
            repeat (3) @(negedge clk);
        end
    endtask

    task automatic applyReset();
        rst_up = 1'b1;
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst_up = 1'b0;
    endtask

    //////////////////////////////
    // script runner
    //////////////////////////////

    initial begin
        int               fd;
        int               code;
        int               a;
        int               b;
        int               c;
        logic [127:0]     cmd;
        logic [63:0]      word;
        logic [8*160-1:0] line;
        logic [7:0]       hexVal;
        rst_up = 1'b1;
        left   = 1'b0;
        right  = 1'b0;
        fall   = 1'b0;
        pause  = 1'b0;
        query  = '0;
        fd = $fopen("tetrisStim.txt", "r");
        if (fd == 0) begin
            $display("Could not open the stimulus file");
            abortRun();
        end
        while ($fscanf(fd, "%s", cmd) == 1) begin
            if (cmd == "#") begin
                code = $fgets(line, fd);
            end else if (cmd == "reset") begin
                applyReset();
            end else if (cmd == "press") begin
                code = $fscanf(fd, "%s %d", word, a);
                pressButton(word == "L", a);
            end else if (cmd == "hold") begin
                code = $fscanf(fd, "%s %d", word, a);
                if (word == "fall") fall = a[0];
                else pause = a[0];
            end else if (cmd == "waitcell") begin
                code = $fscanf(fd, "%d %d %d", a, b, c);
                waitCell(cellAt(a, b), c);
            end else if (cmd == "waitover") begin
                code = $fscanf(fd, "%d", a);
                waitGameOver(a);
            end else if (cmd == "idle") begin
                code = $fscanf(fd, "%d", a);
                repeat (a) @(negedge clk);
            end else if (cmd == "cell") begin
                code = $fscanf(fd, "%d %d %d", a, b, c);
                checkCell(cellAt(a, b), c[0]);
            end else if (cmd == "over") begin
                code = $fscanf(fd, "%d", a);
                checkFlag("gameOver", gameOver, a[0]);
            end else if (cmd == "shape") begin
                code = $fscanf(fd, "%h", hexVal);
                checkShape(nextShape, hexVal);
            end else begin
                $display("Unknown command in the stimulus file");
                abortRun();
            end
        end
        $fclose(fd);
        $display("Simulation passed");
        $finish;
    end

endmodule

// File: tetrisTop.sv
`timescale 1ns/1ps

module tetrisTop #(
    parameter int tickCycles = 25000000
) (
    input  logic                 clk,
    input  logic                 rst_up,
    input  logic                 left,
    input  logic                 right,
    input  logic                 fall,
    input  logic                 pause,
    input  tetrisPkg::cellQueryT query,
    output logic                 cellFilled,
    output logic                 gameOver,
    output tetrisPkg::shapeT     nextShape
);

    logic             tick;
    logic             blocked;
    logic             lock;
    logic             draw;
    tetrisPkg::pieceT probe;
    tetrisPkg::pieceT active;

    gravityTimer #(
        .tickCycles(tickCycles)
    ) i_gravityTimer (
        .clk      (clk),
        .rst_up   (rst_up),
        .fall     (fall),
        .pause    (pause),
        .gameOver (gameOver),
        .tick     (tick)
    );

    pieceSource i_pieceSource (
        .clk       (clk),
        .rst_up    (rst_up),
        .draw      (draw),
        .nextShape (nextShape)
    );

    playfield i_playfield (
        .clk        (clk),
        .rst_up     (rst_up),
        .lock       (lock),
        .probe      (probe),
        .active     (active),
        .query      (query),
        .blocked    (blocked),
        .cellFilled (cellFilled)
    );

    pieceControl i_pieceControl (
        .clk       (clk),
        .rst_up    (rst_up),
        .left      (left),
        .right     (right),
        .pause     (pause),
        .tick      (tick),
        .blocked   (blocked),
        .nextShape (nextShape),
        .probe     (probe),
        .active    (active),
        .lock      (lock),
        .draw      (draw),
        .gameOver  (gameOver)
    );

endmodule

// File: pieceControl.sv
`timescale 1ns/1ps

module pieceControl (
    input  logic             clk,
    input  logic             rst_up,
    input  logic             left,
    input  logic             right,
    input  logic             pause,
    input  logic             tick,
    input  logic             blocked,
    input  tetrisPkg::shapeT nextShape,
    output tetrisPkg::pieceT probe,
    output tetrisPkg::pieceT active,
    output logic             lock,
    output logic             draw,
    output logic             gameOver
);

    localparam tetrisPkg::posT spawnPos = '{
        row: tetrisPkg::rowIdxT'(tetrisPkg::spawnRow),
        col: tetrisPkg::colT'(tetrisPkg::spawnCol)
    };

    // bit 0 is left, bit 1 is right
    logic [1:0] btnMeta;
    logic [1:0] btnSync;
    logic [1:0] btnLast;
    logic [1:0] btnEdge;

    logic moveOk;
    logic doDown;
    logic doLeft;
    logic doRight;
    logic doSpawn;
    logic spawnPending;
    logic moveCommit;

    assign btnEdge = btnSync & ~btnLast;
    assign moveOk  = ~pause & ~gameOver;

    //////////////////////////////
    // probe select
    //////////////////////////////

    // gravity wins over a button edge, which is then lost
    always_comb begin
        doDown  = tick;
        doLeft  = ~tick & moveOk & btnEdge[0];
        doRight = ~tick & moveOk & ~btnEdge[0] & btnEdge[1];
        doSpawn = ~tick & ~doLeft & ~doRight & spawnPending;
        probe   = active;
        if (doDown) begin
            probe.pos.row = active.pos.row + 1'b1;
        end else if (doLeft) begin
            probe.pos.col = active.pos.col - 1'b1;
        end else if (doRight) begin
            probe.pos.col = active.pos.col + 1'b1;
        end else if (doSpawn) begin
            probe.pos = spawnPos;
        end
    end

    assign lock       = doDown & blocked;
    assign draw       = lock;
    assign moveCommit = (doDown | doLeft | doRight) & ~blocked;

    //////////////////////////////
    // piece state
    //////////////////////////////

    always_ff @(posedge clk) begin
        if (rst_up) begin
            btnMeta      <= '0;
            btnSync      <= '0;
            btnLast      <= '0;
            active       <= '{shape: tetrisPkg::shapeTable[0], pos: spawnPos};
            spawnPending <= 1'b0;
            gameOver     <= 1'b0;
        end else begin
            btnMeta <= {right, left};
            btnSync <= btnMeta;
            btnLast <= btnSync;
            if (lock) begin
                active       <= '{shape: nextShape, pos: spawnPos};
                spawnPending <= 1'b1;
            end else if (moveCommit) begin
                active <= probe;
            end
            // new piece overlapping the stack ends the game
            if (doSpawn) begin
                spawnPending <= 1'b0;
                if (blocked) begin
                    gameOver <= 1'b1;
                end
            end
        end
    end

    // gravity must also be frozen once the game is over
    overFreezes: assert property (
        @(posedge clk) disable iff (rst_up) gameOver |-> !(moveCommit || lock)
    );

endmodule

// File: playfield.sv
`timescale 1ns/1ps

module playfield (
    input  logic                 clk,
    input  logic                 rst_up,
    input  logic                 lock,
    input  tetrisPkg::pieceT     probe,
    input  tetrisPkg::pieceT     active,
    input  tetrisPkg::cellQueryT query,
    output logic                 blocked,
    output logic                 cellFilled
);

    tetrisPkg::rowT rows [tetrisPkg::fieldRows];
    tetrisPkg::rowT lockedRows [tetrisPkg::fieldRows];
    logic           queryHit;

    function automatic logic shapeBit(input tetrisPkg::shapeT s, input int r, input int c);
        return s[3'(7 - (r * 4 + c))];
    endfunction

    function automatic logic inField(input int r, input int c);
        return r >= 0 && r < tetrisPkg::fieldRows && c >= 0 && c < tetrisPkg::fieldCols;
    endfunction

    //////////////////////////////
    // collision test
    //////////////////////////////

    // walls and floor count as filled
    always_comb begin
        int cellRow;
        int cellCol;
        blocked = 1'b0;
        for (int r = 0; r < 2; r++) begin
            for (int c = 0; c < 4; c++) begin
                cellRow = int'(probe.pos.row) + r;
                cellCol = int'(probe.pos.col) + c;
                if (shapeBit(probe.shape, r, c)) begin
                    if (!inField(cellRow, cellCol)) begin
                        blocked = 1'b1;
                    end else if (rows[5'(cellRow)][4'(cellCol)]) begin
                        blocked = 1'b1;
                    end
                end
            end
        end
    end

    //////////////////////////////
    // lock and row clear
    //////////////////////////////

    always_comb begin
        tetrisPkg::rowT merged [tetrisPkg::fieldRows];
        int cellRow;
        int cellCol;
        int k;
        merged = rows;
        for (int r = 0; r < 2; r++) begin
            for (int c = 0; c < 4; c++) begin
                cellRow = int'(active.pos.row) + r;
                cellCol = int'(active.pos.col) + c;
                if (shapeBit(active.shape, r, c) && inField(cellRow, cellCol)) begin
                    merged[5'(cellRow)][4'(cellCol)] = 1'b1;
                end
            end
        end
        // copy non-full rows downward, top fills with empty rows
        lockedRows = '{default: '0};
        k = tetrisPkg::fieldRows - 1;
        for (int i = tetrisPkg::fieldRows - 1; i >= 0; i--) begin
            if (merged[5'(i)] != '1) begin
                lockedRows[5'(k)] = merged[5'(i)];
                k--;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst_up) begin
            rows <= '{default: '0};
        end else if (lock) begin
            rows <= lockedRows;
        end
    end

    //////////////////////////////
    // cell query
    //////////////////////////////

    always_comb begin
        int dr;
        int dc;
        dr = int'(query.row) - int'(active.pos.row);
        dc = int'(query.col) - int'(active.pos.col);
        queryHit = 1'b0;
        if (inField(int'(query.row), int'(query.col))) begin
            queryHit = rows[query.row][query.col];
            // falling piece shows on top of the settled cells
            if (dr >= 0 && dr < 2 && dc >= 0 && dc < 4) begin
                queryHit = queryHit | shapeBit(active.shape, dr, dc);
            end
        end
    end

    always_ff @(posedge clk) begin
        cellFilled <= queryHit;
    end

endmodule

// File: pieceSource.sv
`timescale 1ns/1ps

module pieceSource (
    input  logic             clk,
    input  logic             rst_up,
    input  logic             draw,
    output tetrisPkg::shapeT nextShape
);

    localparam int idxW = $clog2(tetrisPkg::pieceCount);

    localparam logic [idxW-1:0] lastIdx = idxW'(tetrisPkg::pieceCount - 1);

    logic [idxW-1:0] drawIdx;

    // piece 0 is already in play after reset, so the queue starts at 1
    always_ff @(posedge clk) begin
        if (rst_up) begin
            drawIdx <= idxW'(1);
        end else if (draw) begin
            if (drawIdx == lastIdx) begin
                drawIdx <= '0;
            end else begin
                drawIdx <= drawIdx + 1'b1;
            end
        end
    end

    assign nextShape = tetrisPkg::shapeTable[drawIdx];

    idxInRange: assert property (
        @(posedge clk) disable iff (rst_up) drawIdx < idxW'(tetrisPkg::pieceCount)
    );

endmodule

// File: gravityTimer.sv
`timescale 1ns/1ps

module gravityTimer #(
    parameter int tickCycles = 25000000
) (
    input  logic clk,
    input  logic rst_up,
    input  logic fall,
    input  logic pause,
    input  logic gameOver,
    output logic tick
);

    // room for the last count plus a double step
    localparam int cntW = $clog2(tickCycles + 2);

    logic [cntW-1:0] count;
    logic [cntW-1:0] countNext;
    logic            run;

    assign run = ~pause & ~gameOver;

    // fast fall steps by two
    assign countNext = count + (fall ? cntW'(2) : cntW'(1));
    assign tick      = run && (countNext >= cntW'(tickCycles));

    always_ff @(posedge clk) begin
        if (rst_up) begin
            count <= '0;
        end else if (tick) begin
            count <= '0;
        end else if (run) begin
            count <= countNext;
        end
    end

    tickPulse: assert property (@(posedge clk) disable iff (rst_up) tick |=> !tick);

endmodule

// File: tetrisPkg.sv
package tetrisPkg;

    //////////////////////////////
    // field geometry
    //////////////////////////////

    localparam int fieldCols  = 10;
    localparam int fieldRows  = 20;
    localparam int spawnCol   = 3;
    localparam int spawnRow   = 0;
    localparam int pieceCount = 7;

    // bit n is column n
    typedef logic [fieldCols-1:0] rowT;

    // top row in [7:4], bottom row in [3:0], left column in the high bit
    typedef logic [7:0] shapeT;

    typedef logic [3:0] colT;
    typedef logic [4:0] rowIdxT;

    // top-left corner of the 2x4 piece box
    typedef struct packed {
        rowIdxT row;
        colT    col;
    } posT;

    typedef struct packed {
        shapeT shape;
        posT   pos;
    } pieceT;

    typedef struct packed {
        rowIdxT row;
        colT    col;
    } cellQueryT;

    //////////////////////////////
    // piece shapes, in draw order
    //////////////////////////////

    localparam shapeT shapeTable [pieceCount] = '{
        8'b1111_0000,
        8'b0100_1110,
        8'b1100_1100,
        8'b0110_1100,
        8'b1100_0110,
        8'b1110_1000,
        8'b1000_1110
    };

endpackage
